//--- vlane_op_pkg.sv
package vlane_op_pkg;

    // Lane operations, multiply and divide are not part of this lane
    typedef enum logic [4:0] {
        VADD, VSUB, VRSUB,
        VAND, VOR, VXOR,
        VSLL, VSRL, VSRA,
        VMSEQ, VMSNE, VMSLTU, VMSLT, VMSLEU, VMSLE, VMSGTU, VMSGT,
        VMINU, VMIN, VMAXU, VMAX,
        VMERGE
    } vlane_op_e;

    typedef enum logic [1:0] {
        EW8,
        EW16,
        EW32
    } vlane_sew_e;

    // Unit that owns an operation, merge sits under CLS_BIT
    typedef enum logic [1:0] {
        CLS_ADD,
        CLS_BIT,
        CLS_CMP,
        CLS_MINMAX
    } op_class_e;

    function automatic op_class_e op_class(input vlane_op_e op);
        case (op)
            VADD, VSUB, VRSUB: return CLS_ADD;
            VMSEQ, VMSNE, VMSLTU, VMSLT, VMSLEU, VMSLE, VMSGTU, VMSGT: return CLS_CMP;
            VMINU, VMIN, VMAXU, VMAX: return CLS_MINMAX;
            default: return CLS_BIT;
        endcase
    endfunction

endpackage

//--- vlane_data_pkg.sv
package vlane_data_pkg;

    localparam int LANE_W = 32;

    // Element counts for the narrow widths
    localparam int NUM_B = 4;
    localparam int NUM_H = 2;

    // One lane word seen as a whole, as bytes or as halfwords
    typedef union packed {
        logic [LANE_W-1:0]      w;
        logic [NUM_B-1:0][7:0]  b;
        logic [NUM_H-1:0][15:0] h;
    } lane_word_u;

endpackage

//--- lane_adder.sv
`timescale 1ns/1ps

module lane_adder (
    input  vlane_op_pkg::vlane_op_e           op_i,
    input  vlane_op_pkg::vlane_sew_e          sew_i,
    input  logic [vlane_data_pkg::LANE_W-1:0] opa_i,
    input  logic [vlane_data_pkg::LANE_W-1:0] opb_i,
    output logic [vlane_data_pkg::LANE_W-1:0] sum_o
);

    vlane_data_pkg::lane_word_u summand_a;
    vlane_data_pkg::lane_word_u sub_src;
    vlane_data_pkg::lane_word_u sub_neg;
    vlane_data_pkg::lane_word_u summand_b;
    vlane_data_pkg::lane_word_u sum_u;
    logic                       is_rsub;
    logic                       is_sub;
    logic                       link;
    logic                       carry;
    logic [8:0]                 byte_sum;

    assign is_rsub = (op_i == vlane_op_pkg::VRSUB);
    assign is_sub  = (op_i == vlane_op_pkg::VSUB) || is_rsub;

    // Reverse subtract swaps the roles of the operands
    assign summand_a.w = is_rsub ? opb_i : opa_i;
    assign sub_src.w   = is_rsub ? opa_i : opb_i;

    // Two's complement taken per element
    always_comb begin
        sub_neg.w = -sub_src.w;
        if (sew_i == vlane_op_pkg::EW8) begin
            for (int i = 0; i < vlane_data_pkg::NUM_B; i++) begin
                sub_neg.b[i] = -sub_src.b[i];
            end
        end else if (sew_i == vlane_op_pkg::EW16) begin
            for (int i = 0; i < vlane_data_pkg::NUM_H; i++) begin
                sub_neg.h[i] = -sub_src.h[i];
            end
        end
    end

    assign summand_b.w = is_sub ? sub_neg.w : opb_i;

    ////////////////////////////////////////
    // Byte sums with segmented carry
    ////////////////////////////////////////

    always_comb begin
        carry = 1'b0;
        for (int i = 0; i < vlane_data_pkg::NUM_B; i++) begin
            // Carry only stays inside one element
            link = ((sew_i == vlane_op_pkg::EW32) && (i != 0)) ||
                   ((sew_i == vlane_op_pkg::EW16) && (i % 2 == 1));
            byte_sum = {1'b0, summand_a.b[i]} + {1'b0, summand_b.b[i]} + {8'd0, link & carry};
            carry = byte_sum[8];
            sum_u.b[i] = byte_sum[7:0];
        end
    end

    assign sum_o = sum_u.w;

endmodule

//--- lane_bitwise.sv
`timescale 1ns/1ps

module lane_bitwise #(
    parameter bit LOGIC_EN = 1'b1
) (
    input  vlane_op_pkg::vlane_op_e           op_i,
    input  vlane_op_pkg::vlane_sew_e          sew_i,
    input  logic [vlane_data_pkg::LANE_W-1:0] opa_i,
    input  logic [vlane_data_pkg::LANE_W-1:0] opb_i,
    output logic [vlane_data_pkg::LANE_W-1:0] bit_o
);

    vlane_data_pkg::lane_word_u opa_u;
    vlane_data_pkg::lane_word_u opb_u;
    vlane_data_pkg::lane_word_u shift_u;
    logic [vlane_data_pkg::LANE_W-1:0] logic_res;

    assign opa_u.w = opa_i;
    assign opb_u.w = opb_i;

    always_comb begin
        case (op_i)
            vlane_op_pkg::VAND: logic_res = opa_i & opb_i;
            vlane_op_pkg::VOR:  logic_res = opa_i | opb_i;
            default:            logic_res = opa_i ^ opb_i;
        endcase
    end

    ////////////////////////////////////////
    // Per-element shifts
    ////////////////////////////////////////

    // Amount comes from the low bits of the matching opb element
    always_comb begin
        shift_u.w = '0;
        case (sew_i)
            vlane_op_pkg::EW8: begin
                for (int i = 0; i < vlane_data_pkg::NUM_B; i++) begin
                    case (op_i)
                        vlane_op_pkg::VSLL: shift_u.b[i] = opa_u.b[i] << opb_u.b[i][2:0];
                        vlane_op_pkg::VSRL: shift_u.b[i] = opa_u.b[i] >> opb_u.b[i][2:0];
                        default: shift_u.b[i] = $signed(opa_u.b[i]) >>> opb_u.b[i][2:0];
                    endcase
                end
            end
            vlane_op_pkg::EW16: begin
                for (int i = 0; i < vlane_data_pkg::NUM_H; i++) begin
                    case (op_i)
                        vlane_op_pkg::VSLL: shift_u.h[i] = opa_u.h[i] << opb_u.h[i][3:0];
                        vlane_op_pkg::VSRL: shift_u.h[i] = opa_u.h[i] >> opb_u.h[i][3:0];
                        default: shift_u.h[i] = $signed(opa_u.h[i]) >>> opb_u.h[i][3:0];
                    endcase
                end
            end
            default: begin
                case (op_i)
                    vlane_op_pkg::VSLL: shift_u.w = opa_u.w << opb_u.w[4:0];
                    vlane_op_pkg::VSRL: shift_u.w = opa_u.w >> opb_u.w[4:0];
                    default:            shift_u.w = $signed(opa_u.w) >>> opb_u.w[4:0];
                endcase
            end
        endcase
    end

    always_comb begin
        if (op_i inside {vlane_op_pkg::VAND, vlane_op_pkg::VOR, vlane_op_pkg::VXOR}) begin
            bit_o = LOGIC_EN ? logic_res : '0;
        end else if (op_i inside {vlane_op_pkg::VSLL, vlane_op_pkg::VSRL, vlane_op_pkg::VSRA}) begin
            bit_o = shift_u.w;
        end else begin
            bit_o = '0;
        end
    end

endmodule

//--- lane_compare.sv
`timescale 1ns/1ps

module lane_compare #(
    parameter bit MINMAX_EN = 1'b1
) (
    input  vlane_op_pkg::vlane_op_e           op_i,
    input  vlane_op_pkg::vlane_sew_e          sew_i,
    input  logic [vlane_data_pkg::LANE_W-1:0] opa_i,
    input  logic [vlane_data_pkg::LANE_W-1:0] opb_i,
    input  logic [vlane_data_pkg::NUM_B-1:0]  mask_i,
    input  logic                              vm_i,
    output logic [vlane_data_pkg::NUM_B-1:0]  cmp_mask_o,
    output logic [vlane_data_pkg::LANE_W-1:0] minmax_o
);

    vlane_data_pkg::lane_word_u opa_u;
    vlane_data_pkg::lane_word_u opb_u;
    vlane_data_pkg::lane_word_u minmax_u;
    logic [vlane_data_pkg::NUM_B-1:0] eq;
    logic [vlane_data_pkg::NUM_B-1:0] gtu;
    logic [vlane_data_pkg::NUM_B-1:0] gts;
    logic [vlane_data_pkg::NUM_B-1:0] elem_en;
    logic [vlane_data_pkg::NUM_B-1:0] cmp_res;
    logic [vlane_data_pkg::NUM_B-1:0] greater;
    logic [vlane_data_pkg::NUM_B-1:0] take_a;

    assign opa_u.w = opa_i;
    assign opb_u.w = opb_i;

    ////////////////////////////////////////
    // Element flags, aligned to low bits
    ////////////////////////////////////////

    always_comb begin
        eq      = '0;
        gtu     = '0;
        gts     = '0;
        elem_en = 4'b0001;
        case (sew_i)
            vlane_op_pkg::EW8: begin
                elem_en = 4'b1111;
                for (int i = 0; i < vlane_data_pkg::NUM_B; i++) begin
                    eq[i]  = opa_u.b[i] == opb_u.b[i];
                    gtu[i] = opa_u.b[i] > opb_u.b[i];
                    gts[i] = $signed(opa_u.b[i]) > $signed(opb_u.b[i]);
                end
            end
            vlane_op_pkg::EW16: begin
                elem_en = 4'b0011;
                for (int i = 0; i < vlane_data_pkg::NUM_H; i++) begin
                    eq[i]  = opa_u.h[i] == opb_u.h[i];
                    gtu[i] = opa_u.h[i] > opb_u.h[i];
                    gts[i] = $signed(opa_u.h[i]) > $signed(opb_u.h[i]);
                end
            end
            default: begin
                eq[0]  = opa_u.w == opb_u.w;
                gtu[0] = opa_u.w > opb_u.w;
                gts[0] = $signed(opa_u.w) > $signed(opb_u.w);
            end
        endcase
    end

    always_comb begin
        case (op_i)
            vlane_op_pkg::VMSNE:  cmp_res = ~eq;
            vlane_op_pkg::VMSLTU: cmp_res = ~eq & ~gtu;
            vlane_op_pkg::VMSLT:  cmp_res = ~eq & ~gts;
            vlane_op_pkg::VMSLEU: cmp_res = ~gtu;
            vlane_op_pkg::VMSLE:  cmp_res = ~gts;
            vlane_op_pkg::VMSGTU: cmp_res = gtu;
            vlane_op_pkg::VMSGT:  cmp_res = gts;
            default:              cmp_res = eq;
        endcase
    end

    // Masked-off and unused elements read as zero
    assign cmp_mask_o = cmp_res & ({vlane_data_pkg::NUM_B{vm_i}} | mask_i) & elem_en;

    ////////////////////////////////////////
    // Min and max
    ////////////////////////////////////////

    assign greater = (op_i inside {vlane_op_pkg::VMIN, vlane_op_pkg::VMAX}) ? gts : gtu;
    assign take_a  = (op_i inside {vlane_op_pkg::VMAX, vlane_op_pkg::VMAXU}) ? greater : ~greater;

    always_comb begin
        minmax_u.w = take_a[0] ? opa_u.w : opb_u.w;
        if (sew_i == vlane_op_pkg::EW8) begin
            for (int i = 0; i < vlane_data_pkg::NUM_B; i++) begin
                minmax_u.b[i] = take_a[i] ? opa_u.b[i] : opb_u.b[i];
            end
        end else if (sew_i == vlane_op_pkg::EW16) begin
            for (int i = 0; i < vlane_data_pkg::NUM_H; i++) begin
                minmax_u.h[i] = take_a[i] ? opa_u.h[i] : opb_u.h[i];
            end
        end
    end

    assign minmax_o = MINMAX_EN ? minmax_u.w : '0;

endmodule

//--- lane_result_stage.sv
`timescale 1ns/1ps

module lane_result_stage #(
    parameter bit MERGE_EN = 1'b1
) (
    input  logic                              clk,
    input  logic                              rst_n_i,
    input  logic                              valid_i,
    input  vlane_op_pkg::vlane_op_e           op_i,
    input  vlane_op_pkg::vlane_sew_e          sew_i,
    input  logic [vlane_data_pkg::LANE_W-1:0] opa_i,
    input  logic [vlane_data_pkg::LANE_W-1:0] opb_i,
    input  logic [vlane_data_pkg::NUM_B-1:0]  mask_i,
    input  logic [vlane_data_pkg::LANE_W-1:0] sum_i,
    input  logic [vlane_data_pkg::LANE_W-1:0] bit_i,
    input  logic [vlane_data_pkg::LANE_W-1:0] minmax_i,
    input  logic [vlane_data_pkg::NUM_B-1:0]  cmp_mask_i,
    output logic                              valid_o,
    output logic [vlane_data_pkg::LANE_W-1:0] result_o,
    output logic [vlane_data_pkg::NUM_B-1:0]  mask_o
);

    vlane_data_pkg::lane_word_u opa_u;
    vlane_data_pkg::lane_word_u opb_u;
    vlane_data_pkg::lane_word_u merge_u;
    logic [vlane_data_pkg::LANE_W-1:0] result_d;
    logic [vlane_data_pkg::NUM_B-1:0]  mask_d;

    assign opa_u.w = opa_i;
    assign opb_u.w = opb_i;

    // Set mask bit takes the opb element
    always_comb begin
        merge_u.w = mask_i[0] ? opb_u.w : opa_u.w;
        if (sew_i == vlane_op_pkg::EW8) begin
            for (int i = 0; i < vlane_data_pkg::NUM_B; i++) begin
                merge_u.b[i] = mask_i[i] ? opb_u.b[i] : opa_u.b[i];
            end
        end else if (sew_i == vlane_op_pkg::EW16) begin
            for (int i = 0; i < vlane_data_pkg::NUM_H; i++) begin
                merge_u.h[i] = mask_i[i] ? opb_u.h[i] : opa_u.h[i];
            end
        end
    end

    ////////////////////////////////////////
    // Result select
    ////////////////////////////////////////

    always_comb begin
        result_d = '0;
        mask_d   = '0;
        if (op_i == vlane_op_pkg::VMERGE) begin
            result_d = MERGE_EN ? merge_u.w : '0;
        end else begin
            case (vlane_op_pkg::op_class(op_i))
                vlane_op_pkg::CLS_ADD: result_d = sum_i;
                vlane_op_pkg::CLS_BIT: result_d = bit_i;
                vlane_op_pkg::CLS_CMP: mask_d = cmp_mask_i;
                default:               result_d = minmax_i;
            endcase
        end
    end

    // Result holds until the next strobe
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_o  <= 1'b0;
            result_o <= '0;
            mask_o   <= '0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                result_o <= result_d;
                mask_o   <= mask_d;
            end
        end
    end

endmodule

//--- vector_lane.sv
`timescale 1ns/1ps

module vector_lane #(
    parameter bit LOGIC_EN  = 1'b1,
    parameter bit MINMAX_EN = 1'b1,
    parameter bit MERGE_EN  = 1'b1
) (
    input  logic                              clk,
    input  logic                              rst_n_i,
    input  logic                              valid_i,
    input  vlane_op_pkg::vlane_op_e           op_i,
    input  vlane_op_pkg::vlane_sew_e          sew_i,
    input  logic [vlane_data_pkg::LANE_W-1:0] opa_i,
    input  logic [vlane_data_pkg::LANE_W-1:0] opb_i,
    input  logic [vlane_data_pkg::NUM_B-1:0]  mask_i,
    input  logic                              vm_i,
    output logic                              valid_o,
    output logic [vlane_data_pkg::LANE_W-1:0] result_o,
    output logic [vlane_data_pkg::NUM_B-1:0]  mask_o
);

    logic [vlane_data_pkg::LANE_W-1:0] sum;
    logic [vlane_data_pkg::LANE_W-1:0] bit_res;
    logic [vlane_data_pkg::LANE_W-1:0] minmax;
    logic [vlane_data_pkg::NUM_B-1:0]  cmp_mask;

    // Combinational units
    lane_adder adder_i (
        .op_i  (op_i),
        .sew_i (sew_i),
        .opa_i (opa_i),
        .opb_i (opb_i),
        .sum_o (sum)
    );

    lane_bitwise #(
        .LOGIC_EN(LOGIC_EN)
    ) bitwise_i (
        .op_i  (op_i),
        .sew_i (sew_i),
        .opa_i (opa_i),
        .opb_i (opb_i),
        .bit_o (bit_res)
    );

    lane_compare #(
        .MINMAX_EN(MINMAX_EN)
    ) compare_i (
        .op_i       (op_i),
        .sew_i      (sew_i),
        .opa_i      (opa_i),
        .opb_i      (opb_i),
        .mask_i     (mask_i),
        .vm_i       (vm_i),
        .cmp_mask_o (cmp_mask),
        .minmax_o   (minmax)
    );

    // Single register stage
    lane_result_stage #(
        .MERGE_EN(MERGE_EN)
    ) result_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .valid_i    (valid_i),
        .op_i       (op_i),
        .sew_i      (sew_i),
        .opa_i      (opa_i),
        .opb_i      (opb_i),
        .mask_i     (mask_i),
        .sum_i      (sum),
        .bit_i      (bit_res),
        .minmax_i   (minmax),
        .cmp_mask_i (cmp_mask),
        .valid_o    (valid_o),
        .result_o   (result_o),
        .mask_o     (mask_o)
    );

endmodule

//--- vector_lane_props.sv
`timescale 1ns/1ps

module vector_lane_props (
    input logic                             clk,
    input logic                             rst_n_i,
    input logic                             valid_i,
    input vlane_op_pkg::vlane_op_e          op_i,
    input vlane_op_pkg::vlane_sew_e         sew_i,
    input logic                             valid_o,
    input logic [vlane_data_pkg::NUM_B-1:0] mask_o
);

    vlane_op_pkg::vlane_op_e          last_op;
    vlane_op_pkg::vlane_sew_e         last_sew;
    logic [vlane_data_pkg::NUM_B-1:0] elem_bits;
    int unsigned                      fail_count = 0;

    // Operation and width behind the registered outputs
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            last_op  <= vlane_op_pkg::VADD;
            last_sew <= vlane_op_pkg::EW8;
        end else if (valid_i) begin
            last_op  <= op_i;
            last_sew <= sew_i;
        end
    end

    assign elem_bits = (last_sew == vlane_op_pkg::EW8)  ? 4'b1111 :
                       (last_sew == vlane_op_pkg::EW16) ? 4'b0011 : 4'b0001;

    valid_follows_strobe: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        $past(rst_n_i) |-> (valid_o == $past(valid_i))
    ) else begin
        $error("valid_o is not valid_i delayed by one cycle");
        fail_count++;
    end

    reset_clears: assert property (
        @(posedge clk) $rose(rst_n_i) |-> (!valid_o && (mask_o == '0))
    ) else begin
        $error("valid_o or mask_o not cleared by reset");
        fail_count++;
    end

    mask_only_compare: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (vlane_op_pkg::op_class(last_op) != vlane_op_pkg::CLS_CMP) |-> (mask_o == '0)
    ) else begin
        $error("mask_o set for a non-compare operation");
        fail_count++;
    end

    mask_in_range: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (mask_o & ~elem_bits) == '0
    ) else begin
        $error("mask_o has bits above the element count");
        fail_count++;
    end

endmodule

//--- tb_vector_lane.sv
`timescale 1ns/1ps

module tb_vector_lane;

    localparam int LANE_W = 32;
    localparam int NUM_EL = 4;
    localparam int PERIOD = 100;
    localparam int N_VEC  = 8;

    // Each directed strobe takes two cycles
    localparam int OPS_TOTAL = 3 * 3 * (N_VEC + 2) + 6 * 3 * N_VEC + 8 * 3 * N_VEC
                             + 4 * 3 * N_VEC + 3 * N_VEC;
    localparam int TEST_CYCLES     = 4 + 2 * OPS_TOTAL + 16;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + 100;

    logic                     clk;
    logic                     rst_n_i;
    logic                     valid_i;
    vlane_op_pkg::vlane_op_e  op_i;
    vlane_op_pkg::vlane_sew_e sew_i;
    logic [LANE_W-1:0]        opa_i;
    logic [LANE_W-1:0]        opb_i;
    logic [NUM_EL-1:0]        mask_i;
    logic                     vm_i;
    logic                     valid_o;
    logic [LANE_W-1:0]        result_o;
    logic [NUM_EL-1:0]        mask_o;

    integer seed   = 32'h26cdf04e;
    int     errors = 0;
    int     checks = 0;
    int     tests  = 0;

    vector_lane #(
        .LOGIC_EN  (1'b1),
        .MINMAX_EN (1'b1),
        .MERGE_EN  (1'b1)
    ) dut_i (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .valid_i  (valid_i),
        .op_i     (op_i),
        .sew_i    (sew_i),
        .opa_i    (opa_i),
        .opb_i    (opb_i),
        .mask_i   (mask_i),
        .vm_i     (vm_i),
        .valid_o  (valid_o),
        .result_o (result_o),
        .mask_o   (mask_o)
    );

    bind vector_lane vector_lane_props props_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (valid_i),
        .op_i    (op_i),
        .sew_i   (sew_i),
        .valid_o (valid_o),
        .mask_o  (mask_o)
    );

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic vlane_op_pkg::vlane_op_e op_of(input int o);
        return vlane_op_pkg::vlane_op_e'(o[4:0]);
    endfunction

    function automatic vlane_op_pkg::vlane_sew_e sew_of(input int s);
        return vlane_op_pkg::vlane_sew_e'(s[1:0]);
    endfunction

    function automatic int elem_width(input vlane_op_pkg::vlane_sew_e sew);
        case (sew)
            vlane_op_pkg::EW8:  return 8;
            vlane_op_pkg::EW16: return 16;
            default:            return 32;
        endcase
    endfunction

    // Sign bit of every element
    function automatic logic [LANE_W-1:0] sign_bits(input vlane_op_pkg::vlane_sew_e sew);
        case (sew)
            vlane_op_pkg::EW8:  return 32'h8080_8080;
            vlane_op_pkg::EW16: return 32'h8000_8000;
            default:            return 32'h8000_0000;
        endcase
    endfunction

    function automatic void ref_model(
        input  vlane_op_pkg::vlane_op_e  op,
        input  vlane_op_pkg::vlane_sew_e sew,
        input  logic [LANE_W-1:0]        a,
        input  logic [LANE_W-1:0]        b,
        input  logic [NUM_EL-1:0]        m,
        input  logic                     vm,
        output logic [LANE_W-1:0]        res,
        output logic [NUM_EL-1:0]        msk
    );
        int          ew;
        logic [31:0] emask;
        logic [31:0] sbit;
        logic [31:0] ea;
        logic [31:0] eb;
        logic [31:0] er;
        logic [31:0] sh;
        logic        lt_u;
        logic        lt_s;
        logic        hit;
        ew    = elem_width(sew);
        emask = (ew == 32) ? 32'hffff_ffff : ((32'd1 << ew) - 32'd1);
        sbit  = 32'd1 << (ew - 1);
        res   = '0;
        msk   = '0;
        for (int k = 0; k < 32 / ew; k++) begin
            ea   = (a >> (k * ew)) & emask;
            eb   = (b >> (k * ew)) & emask;
            sh   = eb & 32'(ew - 1);
            lt_u = ea < eb;
            // Flipped sign bits order signed values as unsigned
            lt_s = (ea ^ sbit) < (eb ^ sbit);
            er   = '0;
            hit  = 1'b0;
            case (op)
                vlane_op_pkg::VADD:   er = ea + eb;
                vlane_op_pkg::VSUB:   er = ea - eb;
                vlane_op_pkg::VRSUB:  er = eb - ea;
                vlane_op_pkg::VAND:   er = ea & eb;
                vlane_op_pkg::VOR:    er = ea | eb;
                vlane_op_pkg::VXOR:   er = ea ^ eb;
                vlane_op_pkg::VSLL:   er = ea << sh;
                vlane_op_pkg::VSRL:   er = ea >> sh;
                vlane_op_pkg::VSRA: begin
                    er = ea >> sh;
                    if ((ea & sbit) != 0) er = er | (emask & ~(emask >> sh));
                end
                vlane_op_pkg::VMSEQ:  hit = (ea == eb);
                vlane_op_pkg::VMSNE:  hit = (ea != eb);
                vlane_op_pkg::VMSLTU: hit = lt_u;
                vlane_op_pkg::VMSLT:  hit = lt_s;
                vlane_op_pkg::VMSLEU: hit = lt_u || (ea == eb);
                vlane_op_pkg::VMSLE:  hit = lt_s || (ea == eb);
                vlane_op_pkg::VMSGTU: hit = !lt_u && (ea != eb);
                vlane_op_pkg::VMSGT:  hit = !lt_s && (ea != eb);
                vlane_op_pkg::VMINU:  er = lt_u ? ea : eb;
                vlane_op_pkg::VMIN:   er = lt_s ? ea : eb;
                vlane_op_pkg::VMAXU:  er = lt_u ? eb : ea;
                vlane_op_pkg::VMAX:   er = lt_s ? eb : ea;
                default:              er = m[k] ? eb : ea;
            endcase
            res    = res | ((er & emask) << (k * ew));
            msk[k] = hit & (vm | m[k]);
        end
    endfunction

    ////////////////////////////////////////
    // Drive and check
    ////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("error: %s got %h expected %h (%s %s)", name, got, exp,
                     op_i.name(), sew_i.name());
            errors++;
        end
    endtask

    task automatic drive_op(input vlane_op_pkg::vlane_op_e op,
                            input vlane_op_pkg::vlane_sew_e sew,
                            input logic [LANE_W-1:0] a, input logic [LANE_W-1:0] b,
                            input logic [NUM_EL-1:0] m, input logic vm);
        valid_i = 1'b1;
        op_i    = op;
        sew_i   = sew;
        opa_i   = a;
        opb_i   = b;
        mask_i  = m;
        vm_i    = vm;
    endtask

    // One strobe with its result checked in the next cycle
    task automatic run_op(input vlane_op_pkg::vlane_op_e op,
                          input vlane_op_pkg::vlane_sew_e sew,
                          input logic [LANE_W-1:0] a, input logic [LANE_W-1:0] b,
                          input logic [NUM_EL-1:0] m, input logic vm);
        logic [LANE_W-1:0] exp_res;
        logic [NUM_EL-1:0] exp_msk;
        ref_model(op, sew, a, b, m, vm, exp_res, exp_msk);
        @(negedge clk);
        drive_op(op, sew, a, b, m, vm);
        @(negedge clk);
        valid_i = 1'b0;
        check_value("valid_o", 32'(valid_o), 32'd1);
        check_value("result_o", result_o, exp_res);
        check_value("mask_o", 32'(mask_o), 32'(exp_msk));
    endtask

    task automatic report_test(input string name, input int start_err);
        tests++;
        $display("%s: %0d errors", name, errors - start_err);
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic arith_test();
        int          start_err;
        logic [31:0] a;
        logic [31:0] b;
        start_err = errors;
        for (int s = 0; s < 3; s++) begin
            for (int o = 0; o <= 2; o++) begin
                // Carry and borrow at every element boundary
                run_op(op_of(o), sew_of(s), 32'h00ff_ffff, 32'h0101_0101, 4'h0, 1'b1);
                run_op(op_of(o), sew_of(s), 32'h0000_0000, 32'h0101_0101, 4'h0, 1'b1);
                for (int i = 0; i < N_VEC; i++) begin
                    a = $random(seed);
                    b = $random(seed);
                    run_op(op_of(o), sew_of(s), a, b, 4'h0, 1'b1);
                end
            end
        end
        report_test("add sub rsub", start_err);
    endtask

    task automatic logic_shift_test();
        int          start_err;
        logic [31:0] a;
        logic [31:0] b;
        start_err = errors;
        for (int s = 0; s < 3; s++) begin
            for (int o = 3; o <= 8; o++) begin
                for (int i = 0; i < N_VEC; i++) begin
                    a = $random(seed);
                    b = $random(seed);
                    run_op(op_of(o), sew_of(s), a, b, 4'h0, 1'b1);
                end
            end
        end
        report_test("logic and shift", start_err);
    endtask

    task automatic compare_test();
        int          start_err;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [3:0]  m;
        start_err = errors;
        for (int s = 0; s < 3; s++) begin
            for (int o = 9; o <= 16; o++) begin
                for (int i = 0; i < N_VEC; i++) begin
                    a = $random(seed);
                    r = $random(seed);
                    m = 4'($random(seed));
                    // Some fully or partly equal operand pairs
                    if (i % 4 == 0) b = a;
                    else if (i % 4 == 1) b = {a[31:16], r[15:0]};
                    else b = r;
                    run_op(op_of(o), sew_of(s), a, b, m, i[0]);
                end
            end
        end
        report_test("compare", start_err);
    endtask

    task automatic minmax_test();
        int          start_err;
        logic [31:0] a;
        logic [31:0] b;
        start_err = errors;
        for (int s = 0; s < 3; s++) begin
            for (int o = 17; o <= 20; o++) begin
                for (int i = 0; i < N_VEC; i++) begin
                    a = $random(seed);
                    b = $random(seed);
                    // Signed and unsigned answers differ here
                    if (i % 2 == 0) b = a ^ sign_bits(sew_of(s));
                    run_op(op_of(o), sew_of(s), a, b, 4'h0, 1'b1);
                end
            end
        end
        report_test("min max", start_err);
    endtask

    task automatic merge_test();
        int          start_err;
        logic [31:0] a;
        logic [31:0] b;
        logic [3:0]  m;
        start_err = errors;
        for (int s = 0; s < 3; s++) begin
            for (int i = 0; i < N_VEC; i++) begin
                a = $random(seed);
                b = $random(seed);
                m = 4'($random(seed));
                run_op(vlane_op_pkg::VMERGE, sew_of(s), a, b, m, i[0]);
            end
        end
        report_test("merge", start_err);
    endtask

    task automatic timing_test();
        int          start_err;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [3:0]  m1;
        logic [3:0]  m2;
        start_err = errors;
        @(negedge clk);
        check_value("valid_o", 32'(valid_o), 32'd0);
        check_value("result_o", result_o, 32'd0);
        check_value("mask_o", 32'(mask_o), 32'd0);
        ref_model(vlane_op_pkg::VMSEQ, vlane_op_pkg::EW8, 32'h1122_3344, 32'h1122_0044,
                  4'h5, 1'b0, r1, m1);
        ref_model(vlane_op_pkg::VADD, vlane_op_pkg::EW16, 32'h0102_ffff, 32'h0101_0001,
                  4'h0, 1'b1, r2, m2);
        // Back-to-back strobes
        drive_op(vlane_op_pkg::VMSEQ, vlane_op_pkg::EW8, 32'h1122_3344, 32'h1122_0044,
                 4'h5, 1'b0);
        @(negedge clk);
        check_value("valid_o", 32'(valid_o), 32'd1);
        check_value("result_o", result_o, r1);
        check_value("mask_o", 32'(mask_o), 32'(m1));
        drive_op(vlane_op_pkg::VADD, vlane_op_pkg::EW16, 32'h0102_ffff, 32'h0101_0001,
                 4'h0, 1'b1);
        @(negedge clk);
        valid_i = 1'b0;
        check_value("valid_o", 32'(valid_o), 32'd1);
        check_value("result_o", result_o, r2);
        check_value("mask_o", 32'(mask_o), 32'(m2));
        // Inputs change without a strobe and the outputs stay
        op_i   = vlane_op_pkg::VMSNE;
        sew_i  = vlane_op_pkg::EW8;
        opa_i  = 32'h5a5a_5a5a;
        opb_i  = 32'ha5a5_a5a5;
        mask_i = 4'hf;
        vm_i   = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_value("valid_o", 32'(valid_o), 32'd0);
            check_value("result_o", result_o, r2);
            check_value("mask_o", 32'(mask_o), 32'(m2));
        end
        // Reset in the middle of the run
        rst_n_i = 1'b0;
        @(negedge clk);
        rst_n_i = 1'b1;
        check_value("valid_o", 32'(valid_o), 32'd0);
        check_value("result_o", result_o, 32'd0);
        check_value("mask_o", 32'(mask_o), 32'd0);
        report_test("timing", start_err);
    endtask

    ////////////////////////////////////////
    // Clock, watchdog and sequence
    ////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("Watchdog expired after %0d cycles, tests did not complete", WATCHDOG_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        rst_n_i = 1'b0;
        valid_i = 1'b0;
        op_i    = vlane_op_pkg::VADD;
        sew_i   = vlane_op_pkg::EW8;
        opa_i   = '0;
        opb_i   = '0;
        mask_i  = '0;
        vm_i    = 1'b0;
        repeat (4) @(negedge clk);
        rst_n_i = 1'b1;
        timing_test();
        arith_test();
        logic_shift_test();
        compare_test();
        minmax_test();
        merge_test();
        // Failed assertions count as errors too
        errors = errors + int'(dut_i.props_i.fail_count);
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- vector_lane.f
vlane_op_pkg.sv
vlane_data_pkg.sv
lane_adder.sv
lane_bitwise.sv
lane_compare.sv
lane_result_stage.sv
vector_lane.sv
vector_lane_props.sv
tb_vector_lane.sv

//--- Makefile
# Verilator build for the vector lane testbench

VERILATOR  ?= verilator
TOP        ?= tb_vector_lane
FILELIST   ?= vector_lane.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 0
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j $(JOBS)
PASS_MSG   ?= Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
